// ==== fir_cfg_top.f ====
+incdir+src
src/fir_cfg_pkg.sv
src/axi4_lite_slave.sv
src/ctrl_reg_block.sv
src/tap_ram.sv
src/fir_cfg_top.sv
test/fir_cfg_tb.sv

// ==== src/axi4_lite_slave.sv ====
`default_nettype none

`include "fir_cfg_macros.svh"

module axi4_lite_slave
  import fir_cfg_pkg::*;
(
  input  wire               aclk,
  input  wire               aresetn,
  // Write address and data
  input  wire axil_wr_t     aw_w,
  input  wire               awvalid,
  input  wire               wvalid,
  output logic              awready,
  output logic              wready,
  // Write response
  output logic              bvalid,
  output axil_resp_t        bresp,
  input  wire               bready,
  // Read address
  input  wire axil_addr_t   araddr,
  input  wire               arvalid,
  output logic              arready,
  // Read data
  output logic              rvalid,
  output axil_data_t        rdata,
  output axil_resp_t        rresp,
  input  wire               rready,
  // Control register
  output ctrl_req_t         ctrl_req,
  input  wire axil_data_t   ctrl_rdata,
  input  wire ctrl_status_t ctrl_status,
  // Tap memory, bus port
  output tap_port_t         tap_port,
  input  wire axil_data_t   tap_rdata
);

  //////////////////////////////////////////////////
  // Address map
  //////////////////////////////////////////////////

  localparam axil_addr_t CTRL_ADDR = axil_addr_t'(`FIR_CTRL_OFS);
  localparam axil_addr_t TAP_BASE  = axil_addr_t'(`FIR_TAP_OFS);
  // First byte past the last tap word
  localparam axil_addr_t TAP_END   = axil_addr_t'(`FIR_TAP_OFS + 4 * `FIR_TAP_NUM);

  slv_state_t state_q;
  // Latched transaction, reads carry no data or strobes
  axil_wr_t   req_q;
  // Tap read issued, memory data arrives next cycle
  logic       rd_pend_q;
  axil_resp_t bresp_q;
  axil_resp_t rresp_q;
  axil_data_t rdata_q;

  logic       hit_ctrl;
  logic       in_tap_win;
  logic       hit_tap;
  axil_addr_t tap_ofs;
  logic       wr_issue;
  logic       rd_issue;

  //////////////////////////////////////////////////
  // Decode of the latched address
  //////////////////////////////////////////////////

  assign hit_ctrl   = (req_q.addr == CTRL_ADDR);
  // Word aligned and inside the tap window
  assign in_tap_win = (req_q.addr >= TAP_BASE) && (req_q.addr < TAP_END) &&
                      (req_q.addr[1:0] == 2'b00);
  // Taps belong to the engine while it runs
  assign hit_tap    = in_tap_win && !ctrl_status.ap_start;
  assign tap_ofs    = req_q.addr - TAP_BASE;

  // Request cycles, one per transaction
  assign wr_issue = (state_q == WR_EXEC);
  assign rd_issue = (state_q == RD_WAIT) && !rd_pend_q;

  //////////////////////////////////////////////////
  // Bus side outputs
  //////////////////////////////////////////////////

  // Address and data accepted together
  assign awready = wr_issue;
  assign wready  = wr_issue;
  assign arready = rd_issue;

  assign bvalid = (state_q == B_RESP);
  assign rvalid = (state_q == R_RESP);
  assign bresp  = bresp_q;
  assign rresp  = rresp_q;
  assign rdata  = rdata_q;

  //////////////////////////////////////////////////
  // Target requests
  //////////////////////////////////////////////////

  always_comb begin
    ctrl_req.wr    = wr_issue && hit_ctrl;
    ctrl_req.rd    = rd_issue && hit_ctrl;
    ctrl_req.wdata = req_q.data;
    ctrl_req.wstrb = req_q.strb;

    // Errored accesses never enable the memory
    tap_port.en    = (wr_issue || rd_issue) && hit_tap;
    tap_port.we    = wr_issue ? req_q.strb : '0;
    tap_port.idx   = tap_idx_t'(tap_ofs >> 2);
    tap_port.wdata = req_q.data;
  end

  //////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      state_q   <= IDLE;
      rd_pend_q <= 1'b0;
      bresp_q   <= `FIR_RESP_OKAY;
      rresp_q   <= `FIR_RESP_OKAY;
    end else begin
      case (state_q)
        IDLE: begin
          // Read wins when both are pending
          if (arvalid) begin
            state_q <= RD_WAIT;
          end else if (awvalid && wvalid) begin
            state_q <= WR_EXEC;
          end
        end
        WR_EXEC: begin
          bresp_q <= (hit_ctrl || hit_tap) ? `FIR_RESP_OKAY : `FIR_RESP_SLVERR;
          state_q <= B_RESP;
        end
        RD_WAIT: begin
          if (rd_pend_q) begin
            // Second cycle of a tap read
            rd_pend_q <= 1'b0;
            rresp_q   <= `FIR_RESP_OKAY;
            state_q   <= R_RESP;
          end else if (hit_tap) begin
            rd_pend_q <= 1'b1;
          end else begin
            // Control answers in the same cycle
            rresp_q <= hit_ctrl ? `FIR_RESP_OKAY : `FIR_RESP_SLVERR;
            state_q <= R_RESP;
          end
        end
        B_RESP: begin
          if (bready) begin
            state_q <= IDLE;
          end
        end
        R_RESP: begin
          if (rready) begin
            state_q <= IDLE;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // Payload capture
  always_ff @(posedge aclk) begin
    if (state_q == IDLE) begin
      if (arvalid) begin
        req_q <= '{addr: araddr, data: '0, strb: '0};
      end else if (awvalid && wvalid) begin
        req_q <= aw_w;
      end
    end
    // Error reads return zero, tap data overwrites one cycle later
    if (state_q == RD_WAIT) begin
      if (rd_pend_q) begin
        rdata_q <= tap_rdata;
      end else begin
        rdata_q <= hit_ctrl ? ctrl_rdata : '0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Protocol checks
  //////////////////////////////////////////////////

  // One transaction in flight, so only one response channel
  a_resp_excl: assert property (@(posedge aclk) disable iff (!aresetn)
    !(bvalid && rvalid));

  a_bvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    bvalid && !bready |=> bvalid && $stable(bresp));

  a_rdata_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

`default_nettype wire

// ==== src/ctrl_reg_block.sv ====
`default_nettype none

module ctrl_reg_block
  import fir_cfg_pkg::*;
(
  input  wire            aclk,
  input  wire            aresetn,
  input  wire ctrl_req_t ctrl_req,
  // One-cycle pulse from the engine
  input  wire            ap_done,
  output axil_data_t     ctrl_rdata,
  output ctrl_status_t   ctrl_status
);

  logic start_q;
  // Sticky until the next read
  logic done_q;
  logic idle_q;
  logic start_hit;

  //////////////////////////////////////////////////
  // Start request
  //////////////////////////////////////////////////

  // Bit 0 of byte 0, only honoured while idle
  assign start_hit = ctrl_req.wr && ctrl_req.wstrb[0] && ctrl_req.wdata[0] && idle_q;

  //////////////////////////////////////////////////
  // Status bits
  //////////////////////////////////////////////////

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      start_q <= 1'b0;
      done_q  <= 1'b0;
      idle_q  <= 1'b1;
    end else begin
      if (start_hit) begin
        start_q <= 1'b1;
        idle_q  <= 1'b0;
      end
      // Read returns the old value, then clears
      if (ctrl_req.rd) begin
        done_q <= 1'b0;
      end
      // A done pulse in the same cycle as a read stays visible
      if (ap_done) begin
        start_q <= 1'b0;
        done_q  <= 1'b1;
        idle_q  <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Read value and status
  //////////////////////////////////////////////////

  always_comb begin
    ctrl_rdata    = '0;
    ctrl_rdata[0] = start_q;
    ctrl_rdata[1] = done_q;
    ctrl_rdata[2] = idle_q;
  end

  // Engine and front end see the live bits
  assign ctrl_status = '{ap_start: start_q, ap_done: done_q, ap_idle: idle_q};

  // Running and idle are exclusive
  a_start_idle: assert property (@(posedge aclk) disable iff (!aresetn)
    !(start_q && idle_q));

endmodule

`default_nettype wire

// ==== src/fir_cfg_macros.svh ====
`ifndef FIR_CFG_MACROS_SVH
`define FIR_CFG_MACROS_SVH

//////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////

// Byte address on the AXI4-Lite side
`define FIR_ADDR_W 12
// Data word, also the tap coefficient width
`define FIR_DATA_W 32

//////////////////////////////////////////////////
// Tap memory
//////////////////////////////////////////////////

`define FIR_TAP_NUM 11
// Word index width, wide enough for FIR_TAP_NUM
`define FIR_TAP_AW 4

//////////////////////////////////////////////////
// Address map and responses
//////////////////////////////////////////////////

// Control register, single word
`define FIR_CTRL_OFS 'h00
// First tap word, one word per tap above it
`define FIR_TAP_OFS 'h20

`define FIR_RESP_OKAY 2'b00
`define FIR_RESP_SLVERR 2'b10

`endif

// ==== src/fir_cfg_pkg.sv ====
`default_nettype none

`include "fir_cfg_macros.svh"

package fir_cfg_pkg;

  //////////////////////////////////////////////////
  // Plain vectors
  //////////////////////////////////////////////////

  typedef logic [`FIR_ADDR_W-1:0]   axil_addr_t;
  typedef logic [`FIR_DATA_W-1:0]   axil_data_t;
  typedef logic [`FIR_DATA_W/8-1:0] axil_strb_t;
  typedef logic [1:0]               axil_resp_t;
  typedef logic [`FIR_TAP_AW-1:0]   tap_idx_t;

  //////////////////////////////////////////////////
  // Grouped signals
  //////////////////////////////////////////////////

  // Write address and write data channels together
  typedef struct packed {
    axil_addr_t addr;
    axil_data_t data;
    axil_strb_t strb;
  } axil_wr_t;

  // Bus side request to the tap memory
  typedef struct packed {
    logic       en;
    axil_strb_t we;
    tap_idx_t   idx;
    axil_data_t wdata;
  } tap_port_t;

  // One-cycle request to the control register
  typedef struct packed {
    logic       wr;
    logic       rd;
    axil_data_t wdata;
    axil_strb_t wstrb;
  } ctrl_req_t;

  typedef struct packed {
    logic ap_start;
    logic ap_done;
    logic ap_idle;
  } ctrl_status_t;

  // Front end sequencer
  typedef enum logic [2:0] {
    IDLE,
    WR_EXEC,
    RD_WAIT,
    B_RESP,
    R_RESP
  } slv_state_t;

endpackage

`default_nettype wire

// ==== src/fir_cfg_top.sv ====
`default_nettype none

module fir_cfg_top
  import fir_cfg_pkg::*;
(
  input  wire             aclk,
  input  wire             aresetn,
  // AXI4-Lite bus
  input  wire axil_wr_t   aw_w,
  input  wire             awvalid,
  input  wire             wvalid,
  output logic            awready,
  output logic            wready,
  output logic            bvalid,
  output axil_resp_t      bresp,
  input  wire             bready,
  input  wire axil_addr_t araddr,
  input  wire             arvalid,
  output logic            arready,
  output logic            rvalid,
  output axil_data_t      rdata,
  output axil_resp_t      rresp,
  input  wire             rready,
  // Engine side
  output logic            ap_start,
  input  wire             ap_done,
  output logic            ap_idle,
  input  wire tap_idx_t   tap_rd_idx,
  output axil_data_t      tap_rd_data
);

  // Front end to targets
  ctrl_req_t    ctrl_req;
  axil_data_t   ctrl_rdata;
  ctrl_status_t ctrl_status;
  tap_port_t    tap_port;
  axil_data_t   tap_rdata;

  assign ap_start = ctrl_status.ap_start;
  assign ap_idle  = ctrl_status.ap_idle;

  //////////////////////////////////////////////////
  // Bus front end
  //////////////////////////////////////////////////

  axi4_lite_slave slave0 (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .aw_w        (aw_w),
    .awvalid     (awvalid),
    .wvalid      (wvalid),
    .awready     (awready),
    .wready      (wready),
    .bvalid      (bvalid),
    .bresp       (bresp),
    .bready      (bready),
    .araddr      (araddr),
    .arvalid     (arvalid),
    .arready     (arready),
    .rvalid      (rvalid),
    .rdata       (rdata),
    .rresp       (rresp),
    .rready      (rready),
    .ctrl_req    (ctrl_req),
    .ctrl_rdata  (ctrl_rdata),
    .ctrl_status (ctrl_status),
    .tap_port    (tap_port),
    .tap_rdata   (tap_rdata)
  );

  //////////////////////////////////////////////////
  // Targets
  //////////////////////////////////////////////////

  ctrl_reg_block ctrl0 (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .ctrl_req    (ctrl_req),
    .ap_done     (ap_done),
    .ctrl_rdata  (ctrl_rdata),
    .ctrl_status (ctrl_status)
  );

  // Port B serves the filter engine
  tap_ram ram0 (
    .aclk    (aclk),
    .port_a  (tap_port),
    .b_idx   (tap_rd_idx),
    .a_rdata (tap_rdata),
    .b_rdata (tap_rd_data)
  );

endmodule

`default_nettype wire

// ==== src/tap_ram.sv ====
`default_nettype none

`include "fir_cfg_macros.svh"

module tap_ram
  import fir_cfg_pkg::*;
(
  input  wire            aclk,
  // Bus port, byte writes and reads
  input  wire tap_port_t port_a,
  // Engine port, read only
  input  wire tap_idx_t  b_idx,
  output axil_data_t     a_rdata,
  output axil_data_t     b_rdata
);

  localparam int STRB_W = `FIR_DATA_W / 8;

  // Coefficient storage, contents survive reset
  axil_data_t mem [`FIR_TAP_NUM];

  //////////////////////////////////////////////////
  // Port A
  //////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (port_a.en) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (port_a.we[b]) begin
          mem[port_a.idx][8*b +: 8] <= port_a.wdata[8*b +: 8];
        end
      end
      // Old word on a write cycle
      a_rdata <= mem[port_a.idx];
    end
  end

  //////////////////////////////////////////////////
  // Port B
  //////////////////////////////////////////////////

  // Registered read every cycle, no enable
  always_ff @(posedge aclk) begin
    b_rdata <= mem[b_idx];
  end

  // Front end decode keeps the bus index in range
  a_idx_range: assert property (@(posedge aclk)
    port_a.en |-> (port_a.idx < `FIR_TAP_NUM));

endmodule

`default_nettype wire

// ==== test/fir_cfg_tb.sv ====
`default_nettype none

`include "fir_cfg_macros.svh"

module fir_cfg_tb
  import fir_cfg_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // Cycles allowed for any single wait
  localparam int LIMIT = 64;
  localparam axil_addr_t CTRL = axil_addr_t'(`FIR_CTRL_OFS);

  logic         aclk = 1'b0;
  logic         aresetn;
  axil_wr_t     aw_w;
  logic         awvalid;
  logic         wvalid;
  logic         awready;
  logic         wready;
  logic         bvalid;
  axil_resp_t   bresp;
  logic         bready;
  axil_addr_t   araddr;
  logic         arvalid;
  logic         arready;
  logic         rvalid;
  axil_data_t   rdata;
  axil_resp_t   rresp;
  logic         rready;
  logic         ap_start;
  logic         ap_done;
  logic         ap_idle;
  tap_idx_t     tap_rd_idx;
  axil_data_t   tap_rd_data;

  int           errors = 0;
  int           checks = 0;
  int           timeouts = 0;
  logic [31:0]  lfsr;
  // Expected tap words, updated byte by byte
  axil_data_t   ref_taps [`FIR_TAP_NUM];

  fir_cfg_top dut0 (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .aw_w        (aw_w),
    .awvalid     (awvalid),
    .wvalid      (wvalid),
    .awready     (awready),
    .wready      (wready),
    .bvalid      (bvalid),
    .bresp       (bresp),
    .bready      (bready),
    .araddr      (araddr),
    .arvalid     (arvalid),
    .arready     (arready),
    .rvalid      (rvalid),
    .rdata       (rdata),
    .rresp       (rresp),
    .rready      (rready),
    .ap_start    (ap_start),
    .ap_done     (ap_done),
    .ap_idle     (ap_idle),
    .tap_rd_idx  (tap_rd_idx),
    .tap_rd_data (tap_rd_data)
  );

  initial begin
    forever #2 aclk = ~aclk;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic axil_addr_t tap_addr(input int i);
    return axil_addr_t'(`FIR_TAP_OFS + 4 * i);
  endfunction

  // Byte lanes with a strobe take the new data
  function automatic axil_data_t merge_bytes(input axil_data_t old, input axil_data_t data,
                                             input axil_strb_t strb);
    axil_data_t v;
    v = old;
    for (int b = 0; b < `FIR_DATA_W / 8; b++) begin
      if (strb[b]) begin
        v[8*b +: 8] = data[8*b +: 8];
      end
    end
    return v;
  endfunction

  task automatic finish_run();
    $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timeout: %s within %0d cycles at %0t", what, LIMIT, $time);
    finish_run();
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  //////////////////////////////////////////////////
  // Bus master and engine model
  //////////////////////////////////////////////////

  // Hold keeps bready low, a read request meanwhile must stay unanswered
  task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                            input axil_strb_t strb, input int hold, output axil_resp_t resp);
    int n;
    @(negedge aclk);
    aw_w    = '{addr: addr, data: data, strb: strb};
    awvalid = 1'b1;
    wvalid  = 1'b1;
    n = 0;
    while (!(awready && wready) && n < LIMIT) begin
      @(negedge aclk);
      n++;
    end
    if (n == LIMIT) report_timeout("awready and wready never rose");
    @(negedge aclk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    n = 0;
    while (!bvalid && n < LIMIT) begin
      @(negedge aclk);
      n++;
    end
    if (n == LIMIT) report_timeout("bvalid never rose");
    resp = bresp;
    for (int i = 0; i < hold; i++) begin
      araddr  = CTRL;
      arvalid = 1'b1;
      @(negedge aclk);
      check_value("bvalid", bvalid, 1'b1);
      check_value("bresp", bresp, resp);
      check_value("arready", arready, 1'b0);
    end
    arvalid = 1'b0;
    bready  = 1'b1;
    @(negedge aclk);
    bready  = 1'b0;
  endtask

  // Hold keeps rready low, a harmless write request waits meanwhile
  task automatic axil_read(input axil_addr_t addr, input int hold,
                           output axil_data_t data, output axil_resp_t resp);
    int n;
    @(negedge aclk);
    araddr  = addr;
    arvalid = 1'b1;
    n = 0;
    while (!arready && n < LIMIT) begin
      @(negedge aclk);
      n++;
    end
    if (n == LIMIT) report_timeout("arready never rose");
    @(negedge aclk);
    arvalid = 1'b0;
    n = 0;
    while (!rvalid && n < LIMIT) begin
      @(negedge aclk);
      n++;
    end
    if (n == LIMIT) report_timeout("rvalid never rose");
    data = rdata;
    resp = rresp;
    for (int i = 0; i < hold; i++) begin
      aw_w    = '{addr: CTRL, data: '0, strb: '0};
      awvalid = 1'b1;
      wvalid  = 1'b1;
      @(negedge aclk);
      check_value("rvalid", rvalid, 1'b1);
      check_value("rdata", rdata, data);
      check_value("rresp", rresp, resp);
      check_value("awready", awready, 1'b0);
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    rready  = 1'b1;
    @(negedge aclk);
    rready  = 1'b0;
  endtask

  task automatic write_expect(input axil_addr_t addr, input axil_data_t data,
                              input axil_strb_t strb, input axil_resp_t exp_resp,
                              input int hold);
    axil_resp_t r;
    axil_write(addr, data, strb, hold, r);
    check_value("bresp", r, exp_resp);
  endtask

  task automatic read_expect(input axil_addr_t addr, input axil_data_t exp_data,
                             input axil_resp_t exp_resp, input int hold);
    axil_data_t d;
    axil_resp_t r;
    axil_read(addr, hold, d, r);
    check_value("rresp", r, exp_resp);
    check_value("rdata", d, exp_data);
  endtask

  // Engine finishing a run
  task automatic pulse_done();
    @(negedge aclk);
    ap_done = 1'b1;
    @(negedge aclk);
    ap_done = 1'b0;
  endtask

  task automatic check_taps();
    for (int i = 0; i < `FIR_TAP_NUM; i++) begin
      read_expect(tap_addr(i), ref_taps[i], `FIR_RESP_OKAY, 0);
    end
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic reset_state();
    @(negedge aclk);
    check_value("arready", arready, 1'b0);
    check_value("awready", awready, 1'b0);
    check_value("wready", wready, 1'b0);
    check_value("bvalid", bvalid, 1'b0);
    check_value("rvalid", rvalid, 1'b0);
    check_value("ap_start", ap_start, 1'b0);
    check_value("ap_idle", ap_idle, 1'b1);
    // Idle bit only
    read_expect(CTRL, 32'h4, `FIR_RESP_OKAY, 0);
  endtask

  task automatic tap_write_read();
    axil_data_t d;
    axil_strb_t s;
    // Full words first so no byte stays unknown, then random strobes
    for (int pass = 0; pass < 2; pass++) begin
      for (int i = 0; i < `FIR_TAP_NUM; i++) begin
        d = rand_bits(32);
        s = (pass == 0) ? '1 : axil_strb_t'(rand_bits(4));
        write_expect(tap_addr(i), d, s, `FIR_RESP_OKAY, 0);
        ref_taps[i] = merge_bytes(ref_taps[i], d, s);
      end
    end
    check_taps();
  endtask

  task automatic engine_port_read();
    for (int i = 0; i < `FIR_TAP_NUM; i++) begin
      @(negedge aclk);
      tap_rd_idx = tap_idx_t'(i);
      @(negedge aclk);
      check_value("tap_rd_data", tap_rd_data, ref_taps[i]);
    end
  endtask

  task automatic bad_address();
    axil_addr_t bad [3];
    // Unmapped, misaligned tap, one word past the last tap
    bad[0] = axil_addr_t'('h10);
    bad[1] = axil_addr_t'(`FIR_TAP_OFS + 2);
    bad[2] = tap_addr(`FIR_TAP_NUM);
    foreach (bad[k]) begin
      write_expect(bad[k], 32'hdead_beef, '1, `FIR_RESP_SLVERR, 0);
      read_expect(bad[k], '0, `FIR_RESP_SLVERR, 0);
    end
    check_taps();
  endtask

  task automatic engine_run();
    write_expect(CTRL, 32'h1, axil_strb_t'(1), `FIR_RESP_OKAY, 0);
    check_value("ap_start", ap_start, 1'b1);
    check_value("ap_idle", ap_idle, 1'b0);
    // Taps belong to the engine now
    write_expect(tap_addr(3), ~ref_taps[3], '1, `FIR_RESP_SLVERR, 0);
    read_expect(CTRL, 32'h1, `FIR_RESP_OKAY, 0);
    pulse_done();
    check_value("ap_start", ap_start, 1'b0);
    check_value("ap_idle", ap_idle, 1'b1);
    // Done and idle, then done cleared by the first read
    read_expect(CTRL, 32'h6, `FIR_RESP_OKAY, 0);
    read_expect(CTRL, 32'h4, `FIR_RESP_OKAY, 0);
    read_expect(tap_addr(3), ref_taps[3], `FIR_RESP_OKAY, 0);
  endtask

  task automatic back_pressure();
    axil_data_t d;
    d = rand_bits(32);
    write_expect(tap_addr(0), d, '1, `FIR_RESP_OKAY, 6);
    ref_taps[0] = d;
    read_expect(tap_addr(0), d, `FIR_RESP_OKAY, 6);
    read_expect(CTRL, 32'h4, `FIR_RESP_OKAY, 6);
    check_taps();
  endtask

  //////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////

  initial begin
    lfsr       = 32'h0379_d559;
    aresetn    = 1'b0;
    aw_w       = '0;
    awvalid    = 1'b0;
    wvalid     = 1'b0;
    bready     = 1'b0;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    ap_done    = 1'b0;
    tap_rd_idx = '0;
    repeat (5) @(negedge aclk);
    aresetn = 1'b1;
    reset_state();
    tap_write_read();
    engine_port_read();
    bad_address();
    engine_run();
    back_pressure();
    finish_run();
  end

endmodule

`default_nettype wire
